//--- src/mul_pkg.sv
package mul_pkg;

    // operand and result width of the multiply unit.
    localparam int DATA_W = 16;

    // each mul8 works on one half of an operand.
    localparam int HALF_W = DATA_W / 2;

    // one add-shift step per multiplier bit.
    localparam int ITER_N = HALF_W;

    localparam int OP_W = 2;

    // low half of the product.
    localparam logic [OP_W-1:0] OP_MUL    = 2'd0;

    // high half, signed x signed.
    localparam logic [OP_W-1:0] OP_MULH   = 2'd1;

    // high half, signed x unsigned.
    localparam logic [OP_W-1:0] OP_MULHSU = 2'd2;

    // high half, unsigned x unsigned.
    localparam logic [OP_W-1:0] OP_MULHU  = 2'd3;

endpackage

//--- src/mul8.sv
module mul8
    import mul_pkg::*;
(
    input  logic                CLK,
    input  logic                reset,
    input  logic [HALF_W-1:0]   multiplicand,
    input  logic [HALF_W-1:0]   multiplier,
    input  logic [1:0]          is_signed,
    input  logic                start,
    output logic                finished,
    output logic [2*HALF_W-1:0] product
);

    logic                        a_neg;
    logic                        b_neg;
    logic [HALF_W-1:0]           a_mag;
    logic [HALF_W-1:0]           b_mag;
    logic [$clog2(ITER_N+1)-1:0] step_cnt;
    logic                        stepping;
    logic                        last_step;
    logic                        negative;
    logic [2*HALF_W-1:0]         mcand_sh;
    logic [HALF_W-1:0]           mplier_sh;
    logic [2*HALF_W-1:0]         acc;
    logic [2*HALF_W-1:0]         addend;
    logic [2*HALF_W-1:0]         sum;

    // an operand is negative only when its sign flag is set.
    assign a_neg = is_signed[1] & multiplicand[HALF_W-1];
    assign b_neg = is_signed[0] & multiplier[HALF_W-1];

    // -8'h80 gives 8'h80, which is the right magnitude read as unsigned.
    assign a_mag = a_neg ? -multiplicand : multiplicand;
    assign b_mag = b_neg ? -multiplier : multiplier;

    assign stepping  = (step_cnt != '0);
    assign last_step = (step_cnt == 1'b1);

    assign addend = mplier_sh[0] ? mcand_sh : '0;
    assign sum    = acc + addend;

    always_ff @(posedge CLK) begin
        if (reset) begin
            step_cnt <= '0;
            finished <= 1'b0;
        end else if (start) begin
            step_cnt <= ITER_N[$clog2(ITER_N+1)-1:0];
            finished <= 1'b0;
        end else if (stepping) begin
            step_cnt <= step_cnt - 1'b1;
            finished <= last_step;
        end
    end

    // magnitude multiply, sign applied on the final step.
    always_ff @(posedge CLK) begin
        if (start) begin
            acc       <= '0;
            mcand_sh  <= {{HALF_W{1'b0}}, a_mag};
            mplier_sh <= b_mag;
            negative  <= a_neg ^ b_neg;
        end else if (stepping) begin
            mcand_sh  <= mcand_sh << 1;
            mplier_sh <= mplier_sh >> 1;
            if (last_step && negative) begin
                acc <= -sum;
            end else begin
                acc <= sum;
            end
        end
    end

    // held until the next start.
    assign product = acc;

endmodule

//--- src/vedic_mul16.sv
module vedic_mul16
    import mul_pkg::*;
(
    input  logic                CLK,
    input  logic                reset,
    input  logic [DATA_W-1:0]   multiplicand,
    input  logic [DATA_W-1:0]   multiplier,
    input  logic [1:0]          is_signed,
    input  logic                start,
    output logic                finished,
    output logic [2*DATA_W-1:0] product
);

    logic [2*HALF_W-1:0] pp [4];
    logic [HALF_W-1:0]   unit_a [4];
    logic [HALF_W-1:0]   unit_b [4];
    logic [1:0]          unit_signed [4];
    logic [3:0]          unit_done;
    logic                ext1;
    logic                ext2;

    // unit 0 hi x hi, unit 1 hi x lo, unit 2 lo x hi, unit 3 lo x lo.
    always_comb begin
        unit_a[0] = multiplicand[DATA_W-1:HALF_W];
        unit_a[1] = multiplicand[DATA_W-1:HALF_W];
        unit_a[2] = multiplicand[HALF_W-1:0];
        unit_a[3] = multiplicand[HALF_W-1:0];

        unit_b[0] = multiplier[DATA_W-1:HALF_W];
        unit_b[1] = multiplier[HALF_W-1:0];
        unit_b[2] = multiplier[DATA_W-1:HALF_W];
        unit_b[3] = multiplier[HALF_W-1:0];

        // only a high half carries the operand sign.
        unit_signed[0] = {is_signed[1], is_signed[0]};
        unit_signed[1] = {is_signed[1], 1'b0};
        unit_signed[2] = {1'b0, is_signed[0]};
        unit_signed[3] = 2'b00;
    end

    for (genvar i = 0; i < 4; i++) begin : g_unit
        mul8 u_mul8 (
            .CLK          (CLK),
            .reset        (reset),
            .multiplicand (unit_a[i]),
            .multiplier   (unit_b[i]),
            .is_signed    (unit_signed[i]),
            .start        (start),
            .finished     (unit_done[i]),
            .product      (pp[i])
        );
    end

    assign finished = &unit_done;

    // a middle partial is negative only if its unit multiplied a signed half.
    assign ext1 = unit_signed[1][1] & pp[1][2*HALF_W-1];
    assign ext2 = unit_signed[2][0] & pp[2][2*HALF_W-1];

    // unit 0 needs no extension, its bits above 2^32 are dropped anyway.
    assign product = {pp[0], {DATA_W{1'b0}}}
                   + {{HALF_W{ext1}}, pp[1], {HALF_W{1'b0}}}
                   + {{HALF_W{ext2}}, pp[2], {HALF_W{1'b0}}}
                   + {{DATA_W{1'b0}}, pp[3]};

endmodule

//--- src/mul_ctrl.sv
module mul_ctrl
    import mul_pkg::*;
(
    input  logic                CLK,
    input  logic                reset,
    input  logic                in_valid,
    output logic                in_ready,
    input  logic [OP_W-1:0]     in_op,
    input  logic [DATA_W-1:0]   in_a,
    input  logic [DATA_W-1:0]   in_b,
    output logic                out_valid,
    input  logic                out_ready,
    output logic [DATA_W-1:0]   out_result,
    output logic [DATA_W-1:0]   multiplicand,
    output logic [DATA_W-1:0]   multiplier,
    output logic [1:0]          is_signed,
    output logic                start,
    input  logic                finished,
    input  logic [2*DATA_W-1:0] product
);

    // idle is neither busy nor done.
    logic       busy;
    logic       done;
    logic       accept;
    logic       mul_done;
    logic [1:0] op_signed;
    logic       op_high;
    logic       high_half;

    assign in_ready  = !busy && !done;
    assign out_valid = done;
    assign accept    = in_valid && in_ready;

    // finished still shows the previous result while start is in flight.
    assign mul_done = busy && !start && finished;

    always_comb begin
        op_signed = 2'b00;
        op_high   = 1'b1;
        case (in_op)
            OP_MUL: begin
                op_high = 1'b0;
            end
            OP_MULH: begin
                op_signed = 2'b11;
            end
            OP_MULHSU: begin
                op_signed = 2'b10;
            end
            OP_MULHU: begin
                op_signed = 2'b00;
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            start <= 1'b0;
        end else begin
            start <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (mul_done) begin
                busy <= 1'b0;
                done <= 1'b1;
            end else if (done && out_ready) begin
                done <= 1'b0;
            end
        end
    end

    // operands stay put until the multiplier finishes.
    always_ff @(posedge CLK) begin
        if (accept) begin
            multiplicand <= in_a;
            multiplier   <= in_b;
            is_signed    <= op_signed;
            high_half    <= op_high;
        end
        if (mul_done) begin
            out_result <= high_half ? product[2*DATA_W-1:DATA_W] : product[DATA_W-1:0];
        end
    end

endmodule

//--- src/mul_top.sv
module mul_top
    import mul_pkg::*;
(
    input  logic              CLK,
    input  logic              reset,
    input  logic              in_valid,
    output logic              in_ready,
    input  logic [OP_W-1:0]   in_op,
    input  logic [DATA_W-1:0] in_a,
    input  logic [DATA_W-1:0] in_b,
    output logic              out_valid,
    input  logic              out_ready,
    output logic [DATA_W-1:0] out_result
);

    logic [DATA_W-1:0]   multiplicand;
    logic [DATA_W-1:0]   multiplier;
    logic [1:0]          is_signed;
    logic                start;
    logic                finished;
    logic [2*DATA_W-1:0] product;

    mul_ctrl u_ctrl (
        .CLK          (CLK),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_op        (in_op),
        .in_a         (in_a),
        .in_b         (in_b),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_result   (out_result),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .is_signed    (is_signed),
        .start        (start),
        .finished     (finished),
        .product      (product)
    );

    vedic_mul16 u_mul (
        .CLK          (CLK),
        .reset        (reset),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .is_signed    (is_signed),
        .start        (start),
        .finished     (finished),
        .product      (product)
    );

endmodule

//--- tb/mul_checker.sv
module mul_checker
    import mul_pkg::*;
(
    input  logic              CLK,
    input  logic              reset,
    input  logic              in_valid,
    input  logic              in_ready,
    input  logic [OP_W-1:0]   in_op,
    input  logic [DATA_W-1:0] in_a,
    input  logic [DATA_W-1:0] in_b,
    input  logic              out_valid,
    input  logic              out_ready,
    input  logic [DATA_W-1:0] out_result,
    input  logic              run_done,
    input  logic              hung,
    output int                error_count,
    output logic              summary_done
);
    timeunit 1ns;
    timeprecision 1ps;

    // each entry is {op, a, b}.
    logic [OP_W+2*DATA_W-1:0] req_q [$];
    int                       req_count = 0;
    int                       resp_count = 0;
    int                       value_errors = 0;
    int                       protocol_errors = 0;
    logic                     any_accepted;
    logic                     held_valid;
    logic [DATA_W-1:0]        held_result;

    // operands are widened by the signedness of the op and multiplied mod 2^32.
    function automatic logic [DATA_W-1:0] expected_result(
        input logic [OP_W-1:0]   op,
        input logic [DATA_W-1:0] a,
        input logic [DATA_W-1:0] b
    );
        logic [2*DATA_W-1:0] a_ext;
        logic [2*DATA_W-1:0] b_ext;
        logic [2*DATA_W-1:0] full;
        a_ext = {{DATA_W{1'b0}}, a};
        b_ext = {{DATA_W{1'b0}}, b};
        if (op == OP_MULH || op == OP_MULHSU) begin
            a_ext = {{DATA_W{a[DATA_W-1]}}, a};
        end
        if (op == OP_MULH) begin
            b_ext = {{DATA_W{b[DATA_W-1]}}, b};
        end
        full = a_ext * b_ext;
        if (op == OP_MUL) begin
            return full[DATA_W-1:0];
        end
        return full[2*DATA_W-1:DATA_W];
    endfunction

    always @(posedge CLK) begin : watch
        logic [OP_W+2*DATA_W-1:0] entry;
        logic [DATA_W-1:0]        expected;
        if (reset) begin
            any_accepted = 1'b0;
            held_valid   = 1'b0;
            error_count  = 0;
            summary_done = 1'b0;
        end else begin
            if (!any_accepted && (!in_ready || out_valid)) begin
                $display("time %0t: after reset in_ready is not high or out_valid is not low",
                         $time);
                protocol_errors++;
            end
            if (held_valid && !out_valid) begin
                $display("time %0t: out_valid dropped before the response was taken", $time);
                protocol_errors++;
            end
            if (held_valid && out_result !== held_result) begin
                $display("FAILED at %0d ns: out_result changed while stalled, expected %h, got %h",
                         $time, held_result, out_result);
                value_errors++;
            end
            if (out_valid && in_ready) begin
                $display("time %0t: in_ready is high while a response is waiting", $time);
                protocol_errors++;
            end
            if (in_valid && in_ready) begin
                if (req_q.size() != 0) begin
                    $display("time %0t: a second request was accepted while one is in flight",
                             $time);
                    protocol_errors++;
                end
                req_q.push_back({in_op, in_a, in_b});
                any_accepted = 1'b1;
                req_count++;
            end
            if (out_valid && out_ready) begin
                resp_count++;
                if (req_q.size() == 0) begin
                    $display("time %0t: a response came with no request outstanding", $time);
                    protocol_errors++;
                end else begin
                    entry    = req_q.pop_front();
                    expected = expected_result(entry[OP_W+2*DATA_W-1:2*DATA_W],
                                               entry[2*DATA_W-1:DATA_W], entry[DATA_W-1:0]);
                    if (out_result !== expected) begin
                        $display(
                            "FAILED at %0d ns: out_result expected %h, got %h (op %0d a %h b %h)",
                            $time, expected, out_result,
                            entry[OP_W+2*DATA_W-1:2*DATA_W],
                            entry[2*DATA_W-1:DATA_W], entry[DATA_W-1:0]);
                        value_errors++;
                    end
                end
            end
            held_valid  = out_valid && !out_ready;
            held_result = out_result;

            if (run_done && !summary_done) begin
                if (req_q.size() != 0) begin
                    $display("missing response: %0d accepted requests were never answered",
                             req_q.size());
                    protocol_errors++;
                end
                error_count = value_errors + protocol_errors + (hung ? 1 : 0);
                $display("%0d req, %0d resp, %0d errors (%0d value, %0d protocol, %0d timeout)",
                         req_count, resp_count, error_count, value_errors, protocol_errors,
                         hung ? 1 : 0);
                summary_done = 1'b1;
            end
        end
    end

endmodule

//--- tb/tb_mul.sv
module tb_mul
    import mul_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_REQ      = 400;
    localparam int DIRECTED_N   = 16;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_GAP      = 3;
    localparam int MAX_STALL    = 4;
    localparam int TIMEOUT_CYCLES =
        2 * (NUM_REQ * (ITER_N + 3 + MAX_GAP + MAX_STALL) + RESET_CYCLES);

    logic              CLK = 1'b0;
    logic              reset;
    logic              in_valid;
    logic              in_ready;
    logic [OP_W-1:0]   in_op;
    logic [DATA_W-1:0] in_a;
    logic [DATA_W-1:0] in_b;
    logic              out_valid;
    logic              out_ready;
    logic [DATA_W-1:0] out_result;
    logic              run_done = 1'b0;
    logic              timed_out = 1'b0;
    logic              summary_done;
    int                error_count;
    integer            seed;
    int                reset_left = RESET_CYCLES;
    int                issued = 0;
    int                accepted = 0;
    int                responded = 0;
    int                cycle_count = 0;
    int                gap_left = 0;
    int                stall_left = 0;

    always #4 CLK = ~CLK;

    mul_top DUT (
        .CLK        (CLK),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_op      (in_op),
        .in_a       (in_a),
        .in_b       (in_b),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result)
    );

    mul_checker u_checker (
        .CLK          (CLK),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_op        (in_op),
        .in_a         (in_a),
        .in_b         (in_b),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_result   (out_result),
        .run_done     (run_done),
        .hung         (timed_out),
        .error_count  (error_count),
        .summary_done (summary_done)
    );

    // one operand in eight is a corner value.
    task automatic pick_operand(output logic [DATA_W-1:0] value);
        logic [31:0] r;
        int unsigned corner;
        r = $random(seed);
        value = r[DATA_W-1:0];
        if (r[31:29] == 3'd0) begin
            corner = $unsigned($random(seed)) % 5;
            case (corner)
                0: value = '0;
                1: value = 16'h0001;
                2: value = '1;
                3: value = 16'h8000;
                default: value = 16'h7fff;
            endcase
        end
    endtask

    // the first requests walk every op over a few fixed corner pairs.
    task automatic present_request();
        logic [31:0] r;
        logic [31:0] idx;
        idx = issued;
        if (issued < DIRECTED_N) begin
            in_op = idx[OP_W-1:0];
            case (idx[3:2])
                2'd0: {in_a, in_b} = {16'hffff, 16'hffff};
                2'd1: {in_a, in_b} = {16'h8000, 16'h8000};
                2'd2: {in_a, in_b} = {16'h8000, 16'h7fff};
                default: {in_a, in_b} = {16'hffff, 16'h7fff};
            endcase
        end else begin
            r = $random(seed);
            in_op = r[OP_W-1:0];
            pick_operand(in_a);
            pick_operand(in_b);
        end
        in_valid = 1'b1;
        issued = issued + 1;
    endtask

    always @(negedge CLK) begin
        if (reset) begin
            reset_left = reset_left - 1;
            if (reset_left == 0) begin
                reset = 1'b0;
            end
        end else begin
            if (in_valid && accepted == issued) begin
                in_valid = 1'b0;
                gap_left = $unsigned($random(seed)) % (MAX_GAP + 1);
            end
            if (!in_valid && issued < NUM_REQ) begin
                if (gap_left != 0) begin
                    gap_left = gap_left - 1;
                end else begin
                    present_request();
                end
            end
            // a stall lasts 1 to MAX_STALL cycles and is followed by at least one ready cycle.
            if (stall_left != 0) begin
                out_ready  = 1'b0;
                stall_left = stall_left - 1;
            end else if (out_ready && ($random(seed) & 3) == 0) begin
                out_ready  = 1'b0;
                stall_left = $unsigned($random(seed)) % MAX_STALL;
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            timed_out <= 1'b1;
        end
        if (!reset) begin
            if (in_valid && in_ready) begin
                accepted <= accepted + 1;
            end
            if (out_valid && out_ready) begin
                responded <= responded + 1;
            end
        end
    end

    initial begin
        seed      = 32'hfbf6_68a4;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_op     = '0;
        in_a      = '0;
        in_b      = '0;
        out_ready = 1'b1;
        wait (responded == NUM_REQ || timed_out);
        if (timed_out) begin
            $display("timeout: the run hung after %0d cycles with %0d of %0d responses",
                     cycle_count, responded, NUM_REQ);
        end
        @(negedge CLK);
        run_done = 1'b1;
        wait (summary_done);
        if (error_count == 0 && !timed_out) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- compile.f
src/mul_pkg.sv
src/mul8.sv
src/vedic_mul16.sv
src/mul_ctrl.sv
src/mul_top.sv
tb/mul_checker.sv
tb/tb_mul.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_mul -f compile.f -o tb_mul
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_mul > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see $LOG"
exit 1
